// File: alu_unit.f
verilog/alu_pkg.sv
verilog/alu_dispatch.sv
verilog/alu_int_unit.sv
verilog/alu_mul_unit.sv
verilog/alu_commit_arb.sv
verilog/alu_unit.sv
verif/alu_unit_checker.sv
verif/alu_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module alu_unit_tb \
    -f alu_unit.f \
    -o alu_unit_sim
./obj_dir/alu_unit_sim

// File: verif/alu_unit_checker.sv
// ********************
// Protocol assertions for the execute stage, bound to alu_unit.
// Covers the commit handshake, the outputs right after reset
// and single branch pulses per integer result.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_unit_checker (
    input wire                       clk,
    input wire                       reset,
    input wire                       req_ready,
    input wire                       commit_valid,
    input wire                       commit_ready,
    input wire alu_pkg::alu_commit_t commit,
    input wire                       branch_valid,
    input wire alu_pkg::alu_commit_t int_rsp
);

    // A stalled commit keeps its valid and its payload
    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        reset |=> !commit_valid && !branch_valid && !req_ready)
        else $error("output active in the cycle after reset");

    // Back-to-back branch pulses must belong to different integer results
    branch_once: assert property (@(posedge clk) disable iff (reset)
        branch_valid && $past(branch_valid) |-> int_rsp.uuid != $past(int_rsp.uuid))
        else $error("branch pulsed twice for one uuid");

endmodule

bind alu_unit alu_unit_checker i_alu_unit_checker (
    .clk          (clk),
    .reset        (reset),
    .req_ready    (req_ready),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit),
    .branch_valid (branch_valid),
    .int_rsp      (int_rsp)
);

`default_nettype wire

// File: verif/alu_unit_tb.sv
// ********************
// Testbench for the SIMT execute stage.
// Issues random integer, branch and multiply requests, models every
// result by uuid and checks commits and branch records under random
// commit back-pressure. Ends through a watchdog if commits stop.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_unit_tb;

    localparam int NUM_REQS   = 400;
    localparam int CLK_PERIOD = 4;
    localparam int TIMEOUT_NS = NUM_REQS * 40 * CLK_PERIOD;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    wire                  req_ready;
    alu_pkg::alu_req_t    req;
    wire                  commit_valid;
    logic                 commit_ready;
    alu_pkg::alu_commit_t commit;
    wire                  branch_valid;
    alu_pkg::alu_branch_t branch;

    alu_pkg::alu_commit_t exp_commit [logic [alu_pkg::UUID_W-1:0]];
    alu_pkg::alu_branch_t exp_branch [logic [alu_pkg::UUID_W-1:0]];
    logic [alu_pkg::UUID_W-1:0] branch_order [$];
    int n_committed;

    alu_unit i_alu_unit (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic check_commit(input alu_pkg::alu_commit_t got, input alu_pkg::alu_commit_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: commit mismatch for uuid %0h, got %h, expected %h",
                     $time, exp.uuid, got, exp);
            fail_run("Commit record differs from the model");
        end
    endtask

    task automatic check_branch(input alu_pkg::alu_branch_t got, input alu_pkg::alu_branch_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: branch mismatch, got %h, expected %h", $time, got, exp);
            fail_run("Branch record differs from the model");
        end
    endtask

    function automatic logic is_branch_op(input alu_pkg::int_op_e op);
        return op inside {alu_pkg::BEQ, alu_pkg::BNE, alu_pkg::BLT, alu_pkg::BGE};
    endfunction

    function automatic alu_pkg::alu_commit_t expected_commit(input alu_pkg::alu_req_t r);
        alu_pkg::alu_commit_t c;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] p;
        longint      sa;
        longint      sb;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        c.wb    = r.wb && (r.is_mul || !is_branch_op(r.op.int_op));
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            a  = r.rs1_data[i];
            b  = r.use_imm ? r.imm : r.rs2_data[i];
            sa = $signed(a);
            sb = $signed(b);
            if (r.is_mul) begin
                if (r.op.mul_op == alu_pkg::MULH)
                    p = sa * sb;
                else
                    p = {32'b0, a} * {32'b0, b};
                c.data[i] = (r.op.mul_op == alu_pkg::MUL) ? p[31:0] : p[63:32];
            end else begin
                case (r.op.int_op)
                    alu_pkg::ADD:  c.data[i] = a + b;
                    alu_pkg::SUB:  c.data[i] = a - b;
                    alu_pkg::AND:  c.data[i] = a & b;
                    alu_pkg::OR:   c.data[i] = a | b;
                    alu_pkg::XOR:  c.data[i] = a ^ b;
                    alu_pkg::SLL:  c.data[i] = a << b[4:0];
                    alu_pkg::SRL:  c.data[i] = a >> b[4:0];
                    alu_pkg::SRA:  c.data[i] = $signed(a) >>> b[4:0];
                    alu_pkg::SLT:  c.data[i] = {31'b0, sa < sb};
                    alu_pkg::SLTU: c.data[i] = {31'b0, a < b};
                    default:       c.data[i] = r.pc + 32'd4;
                endcase
            end
            if (!r.tmask[i])
                c.data[i] = '0;
        end
        return c;
    endfunction

    // The compare uses rs1 and rs2 of the lowest active lane
    function automatic alu_pkg::alu_branch_t expected_branch(input alu_pkg::alu_req_t r);
        alu_pkg::alu_branch_t br;
        int lane;
        lane = -1;
        for (int i = alu_pkg::NUM_LANES - 1; i >= 0; i--)
            if (r.tmask[i])
                lane = i;
        case (r.op.int_op)
            alu_pkg::BEQ: br.taken = r.rs1_data[lane] == r.rs2_data[lane];
            alu_pkg::BNE: br.taken = r.rs1_data[lane] != r.rs2_data[lane];
            alu_pkg::BLT: br.taken = $signed(r.rs1_data[lane]) < $signed(r.rs2_data[lane]);
            default:      br.taken = $signed(r.rs1_data[lane]) >= $signed(r.rs2_data[lane]);
        endcase
        br.wid    = r.wid;
        br.target = br.taken ? r.pc + r.imm : r.pc + 32'd4;
        return br;
    endfunction

    task automatic random_request(input logic [alu_pkg::UUID_W-1:0] uuid,
                                  output alu_pkg::alu_req_t r);
        r         = '0;
        r.uuid    = uuid;
        r.wid     = 2'($urandom_range(3, 0));
        r.tmask   = 4'($urandom_range(15, 1));
        r.pc      = $urandom & 32'hffff_fffc;
        r.is_mul  = 1'($urandom_range(1, 0));
        if (r.is_mul)
            r.op.mul_op = alu_pkg::mul_op_e'(4'($urandom_range(2, 0)));
        else
            r.op.int_op = alu_pkg::int_op_e'(4'($urandom_range(13, 0)));
        r.use_imm = ($urandom_range(3, 0) == 0);
        r.imm     = $urandom;
        r.rd      = 5'($urandom_range(31, 0));
        r.wb      = 1'($urandom_range(1, 0));
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            r.rs1_data[i] = $urandom;
            r.rs2_data[i] = $urandom;
        end
        // Equal operands now and then so equality branches get taken
        if ($urandom_range(3, 0) == 0)
            r.rs2_data = r.rs1_data;
    endtask

    task automatic drive_requests();
        alu_pkg::alu_req_t r;
        logic [alu_pkg::UUID_W-1:0] uuid_ctr;
        logic accepted;
        uuid_ctr = '0;
        for (int n = 0; n < NUM_REQS; n++) begin
            random_request(uuid_ctr, r);
            if (exp_commit.exists(r.uuid))
                fail_run("A uuid was reused while its commit was still outstanding");
            exp_commit[r.uuid] = expected_commit(r);
            if (!r.is_mul && is_branch_op(r.op.int_op)) begin
                exp_branch[r.uuid] = expected_branch(r);
                branch_order.push_back(r.uuid);
            end
            req       = r;
            req_valid = 1'b1;
            accepted  = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = req_ready;
                @(posedge clk);
                #1;
            end
            req_valid = 1'b0;
            uuid_ctr++;
            if ($urandom_range(7, 0) == 0) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Handshakes and pulses are stable by the falling edge
    always @(negedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            if (!exp_commit.exists(commit.uuid)) begin
                fail_run("A commit arrived with a uuid that is not outstanding");
            end else begin
                check_commit(commit, exp_commit[commit.uuid]);
                exp_commit.delete(commit.uuid);
                n_committed++;
            end
        end
        if (!reset && branch_valid) begin
            if (branch_order.size() == 0) begin
                fail_run("A branch record arrived with no branch outstanding");
            end else begin
                check_branch(branch, exp_branch[branch_order[0]]);
                exp_branch.delete(branch_order[0]);
                void'(branch_order.pop_front());
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("Timeout: commits stopped arriving before all requests committed");
    end

    initial begin
        void'($urandom(32'h286c));
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b0;
        n_committed  = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_requests();
            forever begin
                @(posedge clk);
                #1;
                commit_ready = ($urandom_range(99, 0) < 70);
            end
        join_any
        while (n_committed < NUM_REQS)
            @(posedge clk);
        if (branch_order.size() != 0) begin
            fail_run("Branch records are missing at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_commit_arb.sv
// ********************
// Commit side of the execute stage.
// Merges the integer and multiply result streams with a round-robin
// choice into one registered commit port.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_commit_arb (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     int_valid,
    output logic                    int_ready,
    input  wire alu_pkg::alu_commit_t int_rsp,
    input  wire                     mul_valid,
    output logic                    mul_ready,
    input  wire alu_pkg::alu_commit_t mul_rsp,
    output logic                    commit_valid,
    input  wire                     commit_ready,
    output alu_pkg::alu_commit_t    commit
);

    logic out_free;
    logic prio_mul;
    logic int_fire;
    logic mul_fire;

    assign out_free = !commit_valid || commit_ready;

    // An input loses only when the other one is valid and holds priority
    assign int_ready = out_free && !(mul_valid && prio_mul);
    assign mul_ready = out_free && !(int_valid && !prio_mul);

    assign int_fire = int_valid && int_ready;
    assign mul_fire = mul_valid && mul_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            prio_mul     <= 1'b0;
        end else begin
            if (int_fire || mul_fire)
                commit_valid <= 1'b1;
            else if (commit_ready)
                commit_valid <= 1'b0;
            if (int_valid && mul_valid && out_free)
                prio_mul <= ~prio_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (int_fire)
            commit <= int_rsp;
        else if (mul_fire)
            commit <= mul_rsp;
    end

endmodule

`default_nettype wire

// File: verilog/alu_dispatch.sv
// ********************
// Issue side of the execute stage.
// A two-entry skid buffer accepts warp requests and steers the head
// entry to the integer or the multiply unit by its class bit.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_dispatch (
    input  wire                clk,
    input  wire                reset,
    input  wire                req_valid,
    output logic               req_ready,
    input  wire alu_pkg::alu_req_t req,
    output logic               int_valid,
    input  wire                int_ready,
    output alu_pkg::alu_req_t  int_req,
    output logic               mul_valid,
    input  wire                mul_ready,
    output alu_pkg::alu_req_t  mul_req
);

    alu_pkg::alu_req_t entry_q [2];
    alu_pkg::alu_req_t head;
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic              started;
    logic              head_valid;
    logic              push;
    logic              pop;

    assign head       = entry_q[rd_ptr];
    assign head_valid = (count != 2'd0);

    // Held low for one cycle after reset so the issue port sees a clean start
    assign req_ready = started && (count != 2'd2);

    assign int_valid = head_valid && !head.is_mul;
    assign mul_valid = head_valid && head.is_mul;
    assign int_req   = head;
    assign mul_req   = head;

    assign push = req_valid && req_ready;
    assign pop  = head_valid && (head.is_mul ? mul_ready : int_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
        end else begin
            started <= 1'b1;
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entry_q[wr_ptr] <= req;
    end

endmodule

`default_nettype wire

// File: verilog/alu_int_unit.sv
// ********************
// Integer ALU for all lanes with one registered output stage.
// Branch compares are resolved on the lowest active lane and leave
// on the branch port in the cycle the result is registered.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_int_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  wire alu_pkg::alu_req_t in_req,
    output logic                 out_valid,
    input  wire                  out_ready,
    output alu_pkg::alu_commit_t out_rsp,
    output logic                 branch_valid,
    output alu_pkg::alu_branch_t branch
);

    logic [alu_pkg::NUM_LANES-1:0][alu_pkg::XLEN-1:0] lane_res;
    logic [alu_pkg::XLEN-1:0] pc_next;
    logic [alu_pkg::XLEN-1:0] br_target;
    logic [alu_pkg::XLEN-1:0] br_a;
    logic [alu_pkg::XLEN-1:0] br_b;
    logic                     br_taken;
    logic                     is_branch;
    logic                     fire;

    assign in_ready = !out_valid || out_ready;
    assign fire     = in_valid && in_ready;
    assign pc_next  = in_req.pc + 32'd4;

    assign is_branch = (in_req.op.int_op == alu_pkg::BEQ) ||
                       (in_req.op.int_op == alu_pkg::BNE) ||
                       (in_req.op.int_op == alu_pkg::BLT) ||
                       (in_req.op.int_op == alu_pkg::BGE);

    always_comb begin
        logic [alu_pkg::XLEN-1:0] a;
        logic [alu_pkg::XLEN-1:0] b;
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            a = in_req.rs1_data[i];
            b = in_req.use_imm ? in_req.imm : in_req.rs2_data[i];
            lane_res[i] = '0;
            case (in_req.op.int_op)
                alu_pkg::ADD:  lane_res[i] = a + b;
                alu_pkg::SUB:  lane_res[i] = a - b;
                alu_pkg::AND:  lane_res[i] = a & b;
                alu_pkg::OR:   lane_res[i] = a | b;
                alu_pkg::XOR:  lane_res[i] = a ^ b;
                alu_pkg::SLL:  lane_res[i] = a << b[4:0];
                alu_pkg::SRL:  lane_res[i] = a >> b[4:0];
                alu_pkg::SRA:  lane_res[i] = $signed(a) >>> b[4:0];
                alu_pkg::SLT:  lane_res[i][0] = ($signed(a) < $signed(b));
                alu_pkg::SLTU: lane_res[i][0] = (a < b);
                // Branches write the return address
                alu_pkg::BEQ,
                alu_pkg::BNE,
                alu_pkg::BLT,
                alu_pkg::BGE:  lane_res[i] = pc_next;
                default:       lane_res[i] = '0;
            endcase
            if (!in_req.tmask[i])
                lane_res[i] = '0;
        end
    end

    // Pick the operands of the lowest active lane for the compare
    always_comb begin
        logic found;
        found = 1'b0;
        br_a  = '0;
        br_b  = '0;
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            if (in_req.tmask[i] && !found) begin
                br_a  = in_req.rs1_data[i];
                br_b  = in_req.rs2_data[i];
                found = 1'b1;
            end
        end
    end

    always_comb begin
        case (in_req.op.int_op)
            alu_pkg::BEQ: br_taken = (br_a == br_b);
            alu_pkg::BNE: br_taken = (br_a != br_b);
            alu_pkg::BLT: br_taken = ($signed(br_a) < $signed(br_b));
            alu_pkg::BGE: br_taken = ($signed(br_a) >= $signed(br_b));
            default:      br_taken = 1'b0;
        endcase
    end

    assign br_target = br_taken ? (in_req.pc + in_req.imm) : pc_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            if (fire)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
            branch_valid <= fire && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_rsp.uuid  <= in_req.uuid;
            out_rsp.wid   <= in_req.wid;
            out_rsp.tmask <= in_req.tmask;
            out_rsp.pc    <= in_req.pc;
            out_rsp.rd    <= in_req.rd;
            out_rsp.wb    <= in_req.wb && !is_branch;
            out_rsp.data  <= lane_res;
            branch.wid    <= in_req.wid;
            branch.taken  <= br_taken;
            branch.target <= br_target;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_mul_unit.sv
// ********************
// Two-stage lane-parallel multiplier for MUL, MULH and MULHU.
// Stage one forms the 64-bit products, stage two picks the half
// and masks inactive lanes. The pipeline freezes on a blocked output.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_mul_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  wire alu_pkg::alu_req_t in_req,
    output logic                 out_valid,
    input  wire                  out_ready,
    output alu_pkg::alu_commit_t out_rsp
);

    logic [alu_pkg::NUM_LANES-1:0][2*alu_pkg::XLEN-1:0] prod;
    logic [alu_pkg::NUM_LANES-1:0][2*alu_pkg::XLEN-1:0] s1_prod;
    logic [alu_pkg::NUM_LANES-1:0][alu_pkg::XLEN-1:0]   s2_data;
    alu_pkg::alu_commit_t s1_rsp;
    logic                 s1_valid;
    logic                 s1_high;
    logic                 signed_op;
    logic                 advance;

    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    // Only MULH treats both operands as signed
    assign signed_op = (in_req.op.mul_op == alu_pkg::MULH);

    always_comb begin
        logic [alu_pkg::XLEN:0]     a_ext;
        logic [alu_pkg::XLEN:0]     b_ext;
        logic [2*alu_pkg::XLEN+1:0] full;
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            a_ext = {signed_op && in_req.rs1_data[i][alu_pkg::XLEN-1], in_req.rs1_data[i]};
            b_ext = in_req.use_imm ? {signed_op && in_req.imm[alu_pkg::XLEN-1], in_req.imm}
                  : {signed_op && in_req.rs2_data[i][alu_pkg::XLEN-1], in_req.rs2_data[i]};
            full = $signed(a_ext) * $signed(b_ext);
            prod[i] = full[2*alu_pkg::XLEN-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            s2_data[i] = s1_high ? s1_prod[i][2*alu_pkg::XLEN-1:alu_pkg::XLEN]
                                 : s1_prod[i][alu_pkg::XLEN-1:0];
            if (!s1_rsp.tmask[i])
                s2_data[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_prod       <= prod;
            s1_high       <= (in_req.op.mul_op == alu_pkg::MULH) ||
                             (in_req.op.mul_op == alu_pkg::MULHU);
            s1_rsp.uuid   <= in_req.uuid;
            s1_rsp.wid    <= in_req.wid;
            s1_rsp.tmask  <= in_req.tmask;
            s1_rsp.pc     <= in_req.pc;
            s1_rsp.rd     <= in_req.rd;
            s1_rsp.wb     <= in_req.wb;
            s1_rsp.data   <= '0;
            out_rsp       <= s1_rsp;
            out_rsp.data  <= s2_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_pkg.sv
// ********************
// Shared definitions for the SIMT arithmetic execute stage.
// Every module refers to these by scoped names (alu_pkg::name).
// The op union holds both the integer and the multiply opcode views.
// ********************

`default_nettype none

package alu_pkg;

    localparam int NUM_LANES = 4;
    localparam int XLEN      = 32;
    localparam int UUID_W    = 8;
    localparam int WID_W     = 2;
    localparam int NR_W      = 5;

    // Integer opcodes with the branch compares at the end
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13
    } int_op_e;

    // Remaining encodings are reserved
    typedef enum logic [3:0] {
        MUL   = 4'd0,
        MULH  = 4'd1,
        MULHU = 4'd2
    } mul_op_e;

    // The class bit of the request decides which view is valid
    typedef union packed {
        int_op_e int_op;
        mul_op_e mul_op;
    } alu_op_u;

    typedef struct packed {
        logic [UUID_W-1:0]                uuid;
        logic [WID_W-1:0]                 wid;
        logic [NUM_LANES-1:0]             tmask;
        logic [XLEN-1:0]                  pc;
        logic                             is_mul;
        alu_op_u                          op;
        logic                             use_imm;
        logic [XLEN-1:0]                  imm;
        logic [NR_W-1:0]                  rd;
        logic                             wb;
        logic [NUM_LANES-1:0][XLEN-1:0]   rs1_data;
        logic [NUM_LANES-1:0][XLEN-1:0]   rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [UUID_W-1:0]                uuid;
        logic [WID_W-1:0]                 wid;
        logic [NUM_LANES-1:0]             tmask;
        logic [XLEN-1:0]                  pc;
        logic [NR_W-1:0]                  rd;
        logic                             wb;
        logic [NUM_LANES-1:0][XLEN-1:0]   data;
    } alu_commit_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        logic             taken;
        logic [XLEN-1:0]  target;
    } alu_branch_t;

endpackage

`default_nettype wire

// File: verilog/alu_unit.sv
// ********************
// Top of the SIMT arithmetic execute stage.
// Issue requests pass dispatch, the integer or multiply unit and the
// commit arbiter; branch resolutions leave on their own port.
// ********************

`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       req_valid,
    output wire                       req_ready,
    input  wire alu_pkg::alu_req_t    req,
    output wire                       commit_valid,
    input  wire                       commit_ready,
    output wire alu_pkg::alu_commit_t commit,
    output wire                       branch_valid,
    output wire alu_pkg::alu_branch_t branch
);

    wire                       int_valid;
    wire                       int_ready;
    wire alu_pkg::alu_req_t    int_req;
    wire                       mul_valid;
    wire                       mul_ready;
    wire alu_pkg::alu_req_t    mul_req;
    wire                       int_rsp_valid;
    wire                       int_rsp_ready;
    wire alu_pkg::alu_commit_t int_rsp;
    wire                       mul_rsp_valid;
    wire                       mul_rsp_ready;
    wire alu_pkg::alu_commit_t mul_rsp;

    alu_dispatch i_alu_dispatch (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .int_valid (int_valid),
        .int_ready (int_ready),
        .int_req   (int_req),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .mul_req   (mul_req)
    );

    alu_int_unit i_alu_int_unit (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (int_valid),
        .in_ready     (int_ready),
        .in_req       (int_req),
        .out_valid    (int_rsp_valid),
        .out_ready    (int_rsp_ready),
        .out_rsp      (int_rsp),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    alu_mul_unit i_alu_mul_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_req    (mul_req),
        .out_valid (mul_rsp_valid),
        .out_ready (mul_rsp_ready),
        .out_rsp   (mul_rsp)
    );

    alu_commit_arb i_alu_commit_arb (
        .clk          (clk),
        .reset        (reset),
        .int_valid    (int_rsp_valid),
        .int_ready    (int_rsp_ready),
        .int_rsp      (int_rsp),
        .mul_valid    (mul_rsp_valid),
        .mul_ready    (mul_rsp_ready),
        .mul_rsp      (mul_rsp),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

`default_nettype wire
